// ==== list.f ====
rtl/obc_pkg.sv
rtl/obc_mem_if.sv
rtl/obc_fifo_mem.sv
rtl/obc_fifo_ctrl.sv
rtl/obc_afull_agitate.sv
rtl/obc_top.sv
test/obc_asserts.sv
test/obc_tb.sv

// ==== test/obc_tb.sv ====
/*
 * Table-driven testbench for the outbound completion buffer.
 * Each row pushes random entries under one agitator mode and one ready pattern.
 */

module obc_tb
    import obc_pkg::*;
();

    localparam int depth      = 4;   // Same values as the DUT gets
    localparam int afull_wm   = 3;
    localparam int n_rows     = 7;
    localparam int rdy_always = 0;   // cpl_ready held high
    localparam int rdy_never  = 1;   // Low for the stall cycles, then high
    localparam int rdy_alt    = 2;   // Toggles every cycle

    // Stimulus table: entries, mode, ready pattern, stall cycles, overflow row
    int unsigned tbl_cnt   [n_rows] = '{8, 6, 4, 6, 0, 12, 5};
    logic [1:0]  tbl_mode  [n_rows] = '{agit_off, agit_off, agit_off, agit_off,
                                        agit_force, agit_rand, agit_off};
    int          tbl_rdy   [n_rows] = '{rdy_always, rdy_never, rdy_alt, rdy_never,
                                        rdy_always, rdy_never, rdy_always};
    int unsigned tbl_stall [n_rows] = '{0, 12, 0, 10, 6, 20, 0};
    bit          tbl_ovf   [n_rows] = '{0, 0, 0, 1, 0, 0, 0};

    logic                  prim_nonflr_clk = 1'b0;
    logic                  arst_n;
    logic                  push;
    logic [cpl_tag_w-1:0]  push_tag;
    logic [cpl_rid_w-1:0]  push_rid;
    logic [cpl_sts_w-1:0]  push_sts;
    logic [cpl_data_w-1:0] push_data;
    logic                  push_dpar;
    logic [cpl_en_w-1:0]   push_en;
    logic                  cpl_ready;
    logic [1:0]            agit_mode;
    logic                  afull;
    logic                  cpl_v;
    logic [cpl_tag_w-1:0]  cpl_tag;
    logic [cpl_rid_w-1:0]  cpl_rid;
    logic [cpl_sts_w-1:0]  cpl_sts;
    logic [cpl_data_w-1:0] cpl_data;
    logic                  cpl_dpar;
    logic [cpl_en_w-1:0]   cpl_en;
    logic [31:0]           fifo_status;
    logic                  idle;
    logic [31:0]           dbg;

    // Scoreboard, entry word is {tag, rid, sts, dpar, en, data}
    logic [63:0] exp_q [$];
    bit          ovf_seen   = 1'b0;       // Sticky overflow expected
    logic [1:0]  mode_d1    = agit_off;   // Mode seen one edge back
    bit          raw_d1     = 1'b0;       // Watermark state one edge back
    bit          held_v     = 1'b0;       // Entry stalled last cycle
    bit          afull_last = 1'b0;

    obc_top #(
        .depth    (depth),
        .afull_wm (afull_wm)
    ) dut0 (.*);

    always #50 prim_nonflr_clk = ~prim_nonflr_clk;

    // -------------------------------------------------------------------------
    // Checking
    // -------------------------------------------------------------------------

    task automatic check_value(input string name, input logic [63:0] act,
                               input logic [63:0] exp);
        if (act !== exp) begin
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, act, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // A failing bound assertion ends the run at once
    always @(dut0.u_ctrl.u_asserts.fail_cnt) begin
        if (dut0.u_ctrl.u_asserts.fail_cnt != 0) begin
            $display("Error at %0t: an assertion in the FIFO controller failed", $time);
            $display("Something failed");
            $fatal(1);
        end
    end

    // Waits one edge, checks pre-edge outputs, then updates the model
    task automatic sample_edge();
        logic [63:0] front;
        logic [31:0] exp_status;
        int unsigned occ;
        bit          take;
        bit          accept;
        @(posedge prim_nonflr_clk);
        occ = exp_q.size();
        exp_status        = '0;
        exp_status[7:0]   = 8'(occ);
        exp_status[8]     = (occ == depth);
        exp_status[9]     = (occ == 0);
        exp_status[10]    = (occ >= afull_wm);
        exp_status[16]    = ovf_seen;
        check_value("fifo_status", fifo_status, exp_status);
        case (mode_d1)                        // afull is one register behind
            agit_force: check_value("afull", afull, 1'b1);
            agit_rand:  if (raw_d1) check_value("afull", afull, 1'b1);
            default:    check_value("afull", afull, raw_d1);
        endcase
        check_value("idle", idle, !(push || cpl_v));
        if (held_v) check_value("cpl_v", cpl_v, 1'b1);   // Stalled entry stays
        if (occ == 0) check_value("cpl_v", cpl_v, 1'b0);
        take = cpl_v && cpl_ready;
        // Debug flags and zero fill, payload fields only while an entry is valid
        check_value("dbg", {dbg[31:23], dbg[6:3]}, {9'd0, cpl_v, push, take, afull});
        if (cpl_v) begin
            front = exp_q[0];                 // Also covers payload under stall
            check_value("cpl_tag", cpl_tag, front[63:56]);
            check_value("cpl_rid", cpl_rid, front[55:40]);
            check_value("cpl_sts", cpl_sts, front[39:37]);
            check_value("cpl_dpar", cpl_dpar, front[36]);
            check_value("cpl_en", cpl_en, front[35:32]);
            check_value("cpl_data", cpl_data, front[31:0]);
            check_value("dbg", {dbg[22:7], dbg[2:0]},
                        {front[55:48], front[63:56], front[39:37]});
        end
        accept = push && (occ < depth);       // Full FIFO drops the push
        if (push && !accept) ovf_seen = 1'b1;
        if (take) void'(exp_q.pop_front());
        if (accept) exp_q.push_back({push_tag, push_rid, push_sts, push_dpar,
                                     push_en, push_data});
        mode_d1    = agit_mode;
        raw_d1     = (occ >= afull_wm);
        held_v     = cpl_v && !cpl_ready;
        afull_last = afull;
    endtask

    // -------------------------------------------------------------------------
    // Stimulus
    // -------------------------------------------------------------------------

    initial begin
        int unsigned pushed;
        int unsigned row_cyc;
        bit          do_push;
        void'($urandom(11267));
        arst_n    = 1'b0;
        push      = 1'b0;
        push_tag  = '0;
        push_rid  = '0;
        push_sts  = '0;
        push_data = '0;
        push_dpar = 1'b0;
        push_en   = '0;
        cpl_ready = 1'b0;
        agit_mode = agit_off;
        repeat (8) @(posedge prim_nonflr_clk);
        arst_n <= 1'b1;

        // Reset values
        @(posedge prim_nonflr_clk);
        check_value("cpl_v", cpl_v, 1'b0);
        check_value("afull", afull, 1'b0);
        check_value("fifo_status", fifo_status, 32'd0);
        check_value("idle", idle, 1'b1);

        for (int r = 0; r < n_rows; r++) begin
            pushed  = 0;
            row_cyc = 0;
            agit_mode <= tbl_mode[r];
            while (!(pushed == tbl_cnt[r] && row_cyc >= tbl_stall[r]
                     && exp_q.size() == 0)) begin
                // Producer also counts its own entries, afull reacts two cycles late
                do_push = (pushed < tbl_cnt[r])
                          && (tbl_ovf[r] || (!afull_last && exp_q.size() < depth));
                if (do_push) pushed++;
                push      <= do_push;
                push_tag  <= cpl_tag_w'($urandom);
                push_rid  <= cpl_rid_w'($urandom);
                push_sts  <= cpl_sts_w'($urandom);
                push_data <= $urandom;
                push_dpar <= 1'($urandom);
                push_en   <= cpl_en_w'($urandom);
                case (tbl_rdy[r])
                    rdy_never: cpl_ready <= (row_cyc >= tbl_stall[r]);
                    rdy_alt:   cpl_ready <= row_cyc[0];
                    default:   cpl_ready <= 1'b1;
                endcase
                sample_edge();
                row_cyc++;
            end
        end

        // Quiet tail, nothing may come out
        push      <= 1'b0;
        cpl_ready <= 1'b0;
        repeat (3) sample_edge();

        if (dut0.u_ctrl.u_asserts.fail_cnt == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d assertion failures in the FIFO controller",
                     dut0.u_ctrl.u_asserts.fail_cnt);
            $display("Something failed");
            $fatal(1);
        end
    end

    // Watchdog, budget grows with the entries and stalls in the table
    initial begin
        int unsigned budget;
        budget = 20;                          // Reset and tail
        for (int r = 0; r < n_rows; r++) begin
            budget += (tbl_cnt[r] + tbl_stall[r]) * 20;
        end
        repeat (budget) @(posedge prim_nonflr_clk);
        $display("Timeout: the run hung after %0d cycles", budget);
        $display("Something failed");
        $fatal(1);
    end

endmodule

// ==== test/obc_asserts.sv ====
/*
 * Concurrent checks on the FIFO controller, bound into every obc_fifo_ctrl.
 */

module obc_asserts
    import obc_pkg::*;
#(
    parameter int depth    = 4,
    parameter int afull_wm = 3
) (
    input logic                         prim_nonflr_clk,
    input logic                         arst_n,
    input logic [$clog2(depth+1)-1:0]   cnt,         // Controller occupancy
    input logic [$clog2(depth):0]       wptr,        // Write pointer with wrap bit
    input logic [$clog2(depth):0]       rptr,        // Read pointer with wrap bit
    input logic                         rd_pend,     // Entry in the read data stage
    input logic                         out_v,       // Entry in the output register
    input logic                         pop,
    input logic                         pop_data_v,
    input logic [cpl_entry_w-1:0]       pop_data,
    input logic                         afull_raw,
    input logic [31:0]                  status
);

    localparam int aw = $clog2(depth);

    int unsigned fail_cnt = 0;   // Read by the testbench

    logic [aw:0]   arr_occ;   // Entries still in the array
    logic [aw+1:0] occ;       // Occupancy rebuilt from pointers and stages

    assign arr_occ = wptr - rptr;
    assign occ     = arr_occ + rd_pend + out_v;

    // Occupancy bounded by the array size
    a_occ_max : assert property (@(posedge prim_nonflr_clk) disable iff (!arst_n)
        cnt <= depth)
        else begin $error("occupancy %0d above depth", cnt); fail_cnt++; end

    // Output register holds while nobody takes it
    a_out_hold : assert property (@(posedge prim_nonflr_clk) disable iff (!arst_n)
        pop_data_v && !pop |=> pop_data_v && $stable(pop_data))
        else begin $error("output register changed without a pop"); fail_cnt++; end

    // Watermark flag and status against the rebuilt occupancy
    a_wm : assert property (@(posedge prim_nonflr_clk) disable iff (!arst_n)
        (afull_raw == (occ >= afull_wm)) && (status[10] == afull_raw)
        && (status[7:0] == 8'(occ)))
        else begin $error("afull_raw or occupancy disagrees with pointers"); fail_cnt++; end

endmodule

bind obc_fifo_ctrl obc_asserts #(
    .depth    (depth),
    .afull_wm (afull_wm)
) u_asserts (
    .prim_nonflr_clk (prim_nonflr_clk),
    .arst_n          (arst_n),
    .cnt             (cnt),
    .wptr            (wptr),
    .rptr            (rptr),
    .rd_pend         (rd_pend),
    .out_v           (out_v),
    .pop             (pop),
    .pop_data_v      (pop_data_v),
    .pop_data        (pop_data),
    .afull_raw       (afull_raw),
    .status          (status)
);

// ==== rtl/obc_top.sv ====
/*
 * Outbound completion buffer, FIFO of completion entries with valid/ready drain,
 * almost-full agitation, status word, idle level and debug bus.
 */

module obc_top
    import obc_pkg::*;
#(
    parameter int          depth     = 4,         // FIFO entries, power of two
    parameter int          afull_wm  = 3,         // Almost-full watermark
    parameter logic [15:0] agit_seed = 16'h6283   // Agitator LFSR seed
) (
    input  logic                  prim_nonflr_clk,
    input  logic                  arst_n,

    // Push side from the completer
    input  logic                  push,         // Entry strobe, no handshake
    input  logic [cpl_tag_w-1:0]  push_tag,
    input  logic [cpl_rid_w-1:0]  push_rid,
    input  logic [cpl_sts_w-1:0]  push_sts,
    input  logic [cpl_data_w-1:0] push_data,
    input  logic                  push_dpar,    // Carried through unchanged
    input  logic [cpl_en_w-1:0]   push_en,
    output logic                  afull,        // Producer must stop pushing

    // Drain side to the master
    output logic                  cpl_v,        // Entry available
    output logic [cpl_tag_w-1:0]  cpl_tag,
    output logic [cpl_rid_w-1:0]  cpl_rid,
    output logic [cpl_sts_w-1:0]  cpl_sts,
    output logic [cpl_data_w-1:0] cpl_data,
    output logic                  cpl_dpar,
    output logic [cpl_en_w-1:0]   cpl_en,
    input  logic                  cpl_ready,    // Master takes the entry

    // Config and status
    input  logic [1:0]            agit_mode,
    output logic [31:0]           fifo_status,
    output logic                  idle,
    output logic [31:0]           dbg
);

    logic                   pop;         // Transfer on the drain side
    logic                   afull_raw;   // Watermark flag before agitation
    logic [cpl_entry_w-1:0] push_entry;
    logic [cpl_entry_w-1:0] pop_entry;

    // ------------------------------------------------------------------------
    // Entry packing
    // ------------------------------------------------------------------------

    assign push_entry = {push_en, push_tag, push_rid, push_sts, push_dpar, push_data};

    assign {cpl_en, cpl_tag, cpl_rid, cpl_sts, cpl_dpar, cpl_data} = pop_entry;

    assign pop = cpl_v & cpl_ready;

    // ------------------------------------------------------------------------
    // FIFO
    // ------------------------------------------------------------------------

    obc_mem_if #(.depth(depth)) mem_if ();

    obc_fifo_ctrl #(
        .depth    (depth),
        .afull_wm (afull_wm)
    ) u_ctrl (
        .prim_nonflr_clk (prim_nonflr_clk),
        .arst_n          (arst_n),
        .push            (push),
        .push_data       (push_entry),
        .pop             (pop),
        .pop_data_v      (cpl_v),
        .pop_data        (pop_entry),
        .afull_raw       (afull_raw),
        .status          (fifo_status),
        .mem             (mem_if)
    );

    obc_fifo_mem #(.depth(depth)) u_mem (
        .prim_nonflr_clk (prim_nonflr_clk),
        .mem             (mem_if)
    );

    // ------------------------------------------------------------------------
    // Almost-full agitation
    // ------------------------------------------------------------------------

    obc_afull_agitate #(.agit_seed(agit_seed)) u_agit (
        .prim_nonflr_clk (prim_nonflr_clk),
        .arst_n          (arst_n),
        .mode            (agit_mode),
        .in_afull        (afull_raw),
        .out_afull       (afull)
    );

    // Idle whenever nothing enters or waits at the output
    assign idle = ~(push | cpl_v);

    // Debug observation bus
    assign dbg = {9'd0,
                  cpl_rid[15:8],    // 22:15
                  cpl_tag,          // 14:7
                  cpl_v,            // 6
                  push,
                  pop,
                  afull,            // 3
                  cpl_sts};         // 2:0

endmodule

// ==== rtl/obc_afull_agitate.sv ====
/*
 * Almost-full agitator for producer flow-control stress.
 * Registers the flag and can force it high, or randomly high, by mode.
 */

module obc_afull_agitate
    import obc_pkg::*;
#(
    parameter logic [15:0] agit_seed = 16'h6283   // LFSR start value, nonzero
) (
    input  logic       prim_nonflr_clk,
    input  logic       arst_n,

    input  logic [1:0] mode,       // agit_off, agit_rand or agit_force
    input  logic       in_afull,   // Raw almost-full from the FIFO
    output logic       out_afull   // Agitated almost-full, one cycle later
);

    // ------------------------------------------------------------------------
    // 16-bit Fibonacci LFSR
    // ------------------------------------------------------------------------

    logic [15:0] lfsr;
    logic        fb;
    logic        afull_nxt;

    // Taps 16,14,13,11 give a maximal length sequence
    assign fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge prim_nonflr_clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= agit_seed;
        end else begin
            lfsr <= {lfsr[14:0], fb};     // Advances every cycle
        end
    end

    // ------------------------------------------------------------------------
    // Mode select
    // ------------------------------------------------------------------------

    // Every branch keeps in_afull, so the result never drops below it
    always_comb begin
        case (mode)
            agit_rand:  afull_nxt = in_afull | lfsr[0];
            agit_force: afull_nxt = 1'b1;
            agit_off:   afull_nxt = in_afull;
            default:    afull_nxt = in_afull;   // Code 3
        endcase
    end

    // Output stage, adds the one cycle lag on afull
    always_ff @(posedge prim_nonflr_clk or negedge arst_n) begin
        if (!arst_n) begin
            out_afull <= 1'b0;
        end else begin
            out_afull <= afull_nxt;
        end
    end

endmodule

// ==== rtl/obc_fifo_ctrl.sv ====
/*
 * FIFO controller with a registered output stage and a status word.
 * Drives the storage array through obc_mem_if and flags almost-full.
 */

module obc_fifo_ctrl
    import obc_pkg::*;
#(
    parameter int depth    = 4,   // Entries, power of two
    parameter int afull_wm = 3    // Almost-full watermark
) (
    input  logic                   prim_nonflr_clk,
    input  logic                   arst_n,

    input  logic                   push,        // Push strobe from producer
    input  logic [cpl_entry_w-1:0] push_data,   // Entry to push
    input  logic                   pop,         // Output register taken

    output logic                   pop_data_v,  // Output register valid
    output logic [cpl_entry_w-1:0] pop_data,    // Output register payload
    output logic                   afull_raw,   // Occupancy at or above watermark
    output logic [31:0]            status,      // Occupancy, flags, sticky errors

    obc_mem_if.ctrl                mem
);

    localparam int aw = $clog2(depth);       // Array address width
    localparam int cw = $clog2(depth + 1);   // Occupancy counter width

    localparam logic [cw-1:0] wm_lvl  = cw'(afull_wm);
    localparam logic [cw-1:0] full_lvl = cw'(depth);

    // ------------------------------------------------------------------------
    // State
    // ------------------------------------------------------------------------

    logic [aw:0]            wptr;      // Write pointer, extra wrap bit
    logic [aw:0]            rptr;      // Read pointer, extra wrap bit
    logic [cw-1:0]          cnt;       // Pushed and not yet popped
    logic [cw-1:0]          cnt_nxt;
    logic                   rd_pend;   // Array read data waiting in mem.rdata
    logic                   out_v;     // Output register holds an entry
    logic [cpl_entry_w-1:0] out_data;  // Output register payload
    logic                   ovf;       // Sticky overflow
    logic                   udf;       // Sticky underflow
    logic                   ovf_nxt;
    logic                   udf_nxt;

    logic full;
    logic push_ok;     // Push accepted into the array
    logic pop_ok;      // Output register drained
    logic unread;      // Array still holds entries not yet read
    logic ld_out;      // Move read data into output register

    // ------------------------------------------------------------------------
    // Handshake decode
    // ------------------------------------------------------------------------

    assign full    = (cnt == full_lvl);
    assign push_ok = push & ~full;      // Push into a full FIFO is dropped
    assign pop_ok  = pop & out_v;
    assign unread  = (wptr != rptr);

    // Read data moves on when the output register is free or being emptied
    assign ld_out = rd_pend & (~out_v | pop_ok);

    // Array side
    assign mem.we    = push_ok;
    assign mem.waddr = wptr[aw-1:0];
    assign mem.wdata = push_data;
    assign mem.re    = unread & (~out_v | pop_ok);  // Never overwrites pending data
    assign mem.raddr = rptr[aw-1:0];

    // Occupancy includes the read data stage and the output register
    always_comb begin
        cnt_nxt = cnt;
        if (push_ok && !pop_ok) begin
            cnt_nxt = cnt + 1'b1;
        end else if (!push_ok && pop_ok) begin
            cnt_nxt = cnt - 1'b1;
        end
    end

    assign ovf_nxt = ovf | (push & full);
    assign udf_nxt = udf | (pop & ~out_v);  // Pop with nothing to give

    // ------------------------------------------------------------------------
    // Control registers
    // ------------------------------------------------------------------------

    always_ff @(posedge prim_nonflr_clk or negedge arst_n) begin
        if (!arst_n) begin
            wptr    <= '0;
            rptr    <= '0;
            cnt     <= '0;
            rd_pend <= 1'b0;
            out_v   <= 1'b0;
            ovf     <= 1'b0;
            udf     <= 1'b0;
            status  <= '0;
        end else begin
            if (push_ok) wptr <= wptr + 1'b1;
            if (mem.re)  rptr <= rptr + 1'b1;

            cnt <= cnt_nxt;

            if (mem.re) begin
                rd_pend <= 1'b1;   // Data lands in mem.rdata next edge
            end else if (ld_out) begin
                rd_pend <= 1'b0;
            end

            if (ld_out) begin
                out_v <= 1'b1;
            end else if (pop_ok) begin
                out_v <= 1'b0;
            end

            ovf <= ovf_nxt;
            udf <= udf_nxt;

            // Status follows the count at the same edge
            status <= {14'd0,
                       udf_nxt,                   // 17
                       ovf_nxt,                   // 16
                       5'd0,
                       (cnt_nxt >= wm_lvl),       // 10 afull_raw
                       (cnt_nxt == '0),           // 9  empty
                       (cnt_nxt == full_lvl),     // 8  full
                       8'(cnt_nxt)};              // 7:0 occupancy
        end
    end

    // Output payload
    always_ff @(posedge prim_nonflr_clk) begin
        if (ld_out) out_data <= mem.rdata;
    end

    assign pop_data_v = out_v;
    assign pop_data   = out_data;
    assign afull_raw  = (cnt >= wm_lvl);

endmodule

// ==== rtl/obc_fifo_mem.sv ====
/*
 * Flop storage for the completion FIFO, synchronous write, registered read.
 */

module obc_fifo_mem
    import obc_pkg::*;
#(
    parameter int depth = 4   // Entries
) (
    input  logic   prim_nonflr_clk,
    obc_mem_if.mem mem
);

    // ------------------------------------------------------------------------
    // Storage array
    // ------------------------------------------------------------------------

    logic [cpl_entry_w-1:0] arr [depth];   // One slot per FIFO entry

    always_ff @(posedge prim_nonflr_clk) begin
        if (mem.we) begin
            arr[mem.waddr] <= mem.wdata;     // Write slot
        end
    end

    // Read data register holds its value while re is low
    always_ff @(posedge prim_nonflr_clk) begin
        if (mem.re) begin
            mem.rdata <= arr[mem.raddr];
        end
    end

    // Controller only reads slots written on an earlier edge,
    // and never writes the slot being read

endmodule

// ==== rtl/obc_mem_if.sv ====
/*
 * Write and read port between the FIFO controller and its storage array.
 * Read data comes back one cycle after the read enable.
 */

interface obc_mem_if
    import obc_pkg::*;
#(
    parameter int depth = 4
) ();

    localparam int aw = $clog2(depth);  // Array address width

    logic                   we;     // Write enable
    logic [aw-1:0]          waddr;  // Write slot
    logic [cpl_entry_w-1:0] wdata;  // Entry to store
    logic                   re;     // Read enable
    logic [aw-1:0]          raddr;  // Read slot
    logic [cpl_entry_w-1:0] rdata;  // Registered read data

    // Controller side
    modport ctrl (
        output we, waddr, wdata, re, raddr,
        input  rdata
    );

    // Storage side
    modport mem (
        input  we, waddr, wdata, re, raddr,
        output rdata
    );

endinterface

// ==== rtl/obc_pkg.sv ====
/*
 * Shared widths and agitator mode codes for the outbound completion buffer.
 * Imported by the RTL modules and by the testbench.
 */

package obc_pkg;

    // ------------------------------------------------------------------------
    // Completion entry fields
    // ------------------------------------------------------------------------

    localparam int cpl_tag_w  = 8;   // Completion tag
    localparam int cpl_rid_w  = 16;  // Requester ID
    localparam int cpl_sts_w  = 3;   // Completion status
    localparam int cpl_data_w = 32;  // Data word
    localparam int cpl_en_w   = 4;   // Enables field

    // Whole entry as stored in the FIFO, one parity bit on top of the fields
    localparam int cpl_entry_w = cpl_tag_w
                               + cpl_rid_w
                               + cpl_sts_w
                               + cpl_data_w
                               + cpl_en_w
                               + 1;

    // ------------------------------------------------------------------------
    // Almost-full agitator modes
    // ------------------------------------------------------------------------

    // Code 3 is not defined and acts like agit_off
    localparam logic [1:0] agit_off   = 2'd0;  // Plain registered afull
    localparam logic [1:0] agit_rand  = 2'd1;  // Afull or-ed with LFSR bit
    localparam logic [1:0] agit_force = 2'd2;  // Afull held high

endpackage
